// File: common/pe_types_pkg.sv
`default_nettype none

package pe_types_pkg;

    //////////////////////////////////////////////////
    // Sample format
    //////////////////////////////////////////////////

    localparam int DATA_WIDTH = 16;  // One part of a complex sample

    // Real part in the upper half, imaginary in the lower
    typedef struct packed {
        logic signed [DATA_WIDTH-1:0] re;
        logic signed [DATA_WIDTH-1:0] im;
    } cplx_t;

    //////////////////////////////////////////////////
    // Data memory geometry
    //////////////////////////////////////////////////

    localparam int DMEM_AW    = 4;
    localparam int DMEM_DEPTH = 2 ** DMEM_AW;  // 16 complex entries

    typedef logic [DMEM_AW-1:0] dmem_addr_t;

endpackage

`default_nettype wire

// File: common/pe_isa_pkg.sv
`default_nettype none

package pe_isa_pkg;

    localparam int INST_WIDTH = 32;

    // Field widths, top bit down
    localparam int OP_W   = 4;
    localparam int WSRC_W = 2;
    localparam int REG_W  = 4;   // dst, src0, src1
    localparam int RSVD_W = INST_WIDTH - OP_W - WSRC_W - 3 * REG_W;  // 14 spare bits

    //////////////////////////////////////////////////
    // Opcodes
    //////////////////////////////////////////////////

    typedef enum logic [OP_W-1:0] {
        NOP   = 4'h0,  // No ALU issue
        CADD  = 4'h1,  // a + b
        CSUB  = 4'h2,  // a - b
        CMUL  = 4'h3,  // a * b
        CMULC = 4'h4,  // a * conj(b)
        PASS  = 4'h5,  // a
        END   = 4'hF   // Last word, pc wraps after it
    } op_t;

    // Where the data memory write comes from
    typedef enum logic [WSRC_W-1:0] {
        W_NONE = 2'd0,  // no write this step
        W_LD   = 2'd1,  // load bus
        W_PE   = 2'd2,  // neighbour PE
        W_WB   = 2'd3   // own last result
    } wsrc_t;

    //////////////////////////////////////////////////
    // Instruction word
    //////////////////////////////////////////////////

    typedef struct packed {
        op_t               op;
        wsrc_t             wsrc;
        logic [REG_W-1:0]  dst;
        logic [REG_W-1:0]  src0;
        logic [REG_W-1:0]  src1;
        logic [RSVD_W-1:0] rsvd;
    } inst_t;

endpackage

`default_nettype wire

// File: common/dmem_if.sv
`timescale 1ns/1ns
`default_nettype none

// Data memory ports between decoder, register file and ALU
interface dmem_if import pe_types_pkg::*; ();

    logic       rden;      // Latch both read ports
    dmem_addr_t rd_addr0;  // Operand a
    dmem_addr_t rd_addr1;  // Operand b

    logic       wren;
    dmem_addr_t wr_addr;
    cplx_t      wdata;

    cplx_t      rdata0;    // Registered, one cycle after rden
    cplx_t      rdata1;

    // Decoder side
    modport ctrl (output rden, rd_addr0, rd_addr1, wren, wr_addr, wdata);

    // Register file
    modport mem (
        input  rden, rd_addr0, rd_addr1, wren, wr_addr, wdata,
        output rdata0, rdata1
    );

    // ALU only sees the operands
    modport alu (input rdata0, rdata1);

endinterface

`default_nettype wire

// File: hw/complex_alu.sv
`timescale 1ns/1ns
`default_nettype none

module complex_alu import pe_types_pkg::*, pe_isa_pkg::*; #(
    parameter int FRAC_BITS = 8
) (
    input  wire        clk,
    input  wire        rst,
    input  wire        alu_v,
    input  wire op_t   alu_op,
    dmem_if.alu        opnd,     // a = rdata0, b = rdata1
    output logic       dout_v,
    output cplx_t      dout
);

    localparam int PW = 2 * DATA_WIDTH + 1;  // Sum of two products

    cplx_t a;
    cplx_t b;
    cplx_t res;

    logic signed [PW-1:0] p_rr;   // ar*br
    logic signed [PW-1:0] p_ii;   // ai*bi
    logic signed [PW-1:0] p_ri;   // ar*bi
    logic signed [PW-1:0] p_ir;   // ai*br
    logic signed [PW-1:0] mul_re;
    logic signed [PW-1:0] mul_im;
    logic signed [PW-1:0] sh_re;
    logic signed [PW-1:0] sh_im;

    assign a = opnd.rdata0;
    assign b = opnd.rdata1;

    //////////////////////////////////////////////////
    // Multiplier
    //////////////////////////////////////////////////

    assign p_rr = PW'(a.re) * PW'(b.re);  // Signed, widened to PW
    assign p_ii = PW'(a.im) * PW'(b.im);
    assign p_ri = PW'(a.re) * PW'(b.im);
    assign p_ir = PW'(a.im) * PW'(b.re);

    always_comb begin
        if (alu_op == CMULC) begin
            // b conjugated, bi negated
            mul_re = p_rr + p_ii;
            mul_im = p_ir - p_ri;
        end else begin
            mul_re = p_rr - p_ii;
            mul_im = p_ri + p_ir;
        end
    end

    assign sh_re = mul_re >>> FRAC_BITS;  // Arithmetic, fixed point back
    assign sh_im = mul_im >>> FRAC_BITS;

    //////////////////////////////////////////////////
    // Result select and output register
    //////////////////////////////////////////////////

    always_comb begin
        case (alu_op)
            CADD: begin
                res.re = a.re + b.re;  // Wraps mod 2^16
                res.im = a.im + b.im;
            end
            CSUB: begin
                res.re = a.re - b.re;
                res.im = a.im - b.im;
            end
            CMUL, CMULC: begin
                res.re = sh_re[DATA_WIDTH-1:0];  // Low 16 bits only
                res.im = sh_im[DATA_WIDTH-1:0];
            end
            default: res = a;  // PASS
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            dout_v <= 1'b0;
        end else begin
            dout_v <= alu_v;
        end
    end

    always_ff @(posedge clk) begin
        if (alu_v) begin
            dout <= res;  // Held between results
        end
    end

endmodule

`default_nettype wire

// File: pe/pe_imem.sv
`timescale 1ns/1ns
`default_nettype none

module pe_imem import pe_isa_pkg::*; #(
    parameter int IMEM_DEPTH = 32
) (
    input  wire                   clk,
    input  wire                   rst,
    input  wire                   inst_in_v,
    input  wire [INST_WIDTH-1:0]  inst_in,
    input  wire                   step,       // Advance pc, din_v
    output inst_t                 inst
);

    localparam int AW = $clog2(IMEM_DEPTH);

    logic [INST_WIDTH-1:0] mem [IMEM_DEPTH];

    logic          load_q;       // inst_in_v one cycle back
    logic          burst_start;
    logic [AW-1:0] ld_ptr;
    logic [AW-1:0] wr_addr;
    logic [AW:0]   prog_len;     // Words in the current program
    logic [AW-1:0] pc;
    logic [AW:0]   pc_inc;       // One extra bit to compare against length

    // Rising edge of inst_in_v restarts the load at 0
    assign burst_start = inst_in_v && !load_q;
    assign wr_addr     = burst_start ? '0 : ld_ptr;
    assign pc_inc      = {1'b0, pc} + 1'b1;

    assign inst = inst_t'(mem[pc]);  // Async read at pc

    always_ff @(posedge clk) begin
        if (inst_in_v) begin
            mem[wr_addr] <= inst_in;
        end
    end

    //////////////////////////////////////////////////
    // Load pointer and program counter
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            load_q   <= 1'b0;
            ld_ptr   <= '0;
            prog_len <= '0;
            pc       <= '0;
        end else begin
            load_q <= inst_in_v;
            if (inst_in_v) begin
                ld_ptr   <= wr_addr + 1'b1;
                prog_len <= {1'b0, wr_addr} + 1'b1;  // Grows with each beat
            end
            if (burst_start) begin
                pc <= '0;                            // New program
            end else if (step) begin
                if (inst.op == END || pc_inc >= prog_len) begin
                    pc <= '0;                        // Wrap
                end else begin
                    pc <= pc_inc[AW-1:0];
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: pe/pe_control.sv
`timescale 1ns/1ns
`default_nettype none

module pe_control import pe_types_pkg::*, pe_isa_pkg::*; (
    input  wire         clk,
    input  wire         rst,
    input  wire inst_t  inst,
    input  wire         din_v,
    input  wire cplx_t  din_ld,
    input  wire cplx_t  din_pe,
    input  wire cplx_t  din_wb,   // ALU output register
    dmem_if.ctrl        dmem,
    output logic        alu_v,
    output op_t         alu_op
);

    logic issue;  // ALU op this cycle

    // NOP and END only step the pc
    assign issue = din_v && (inst.op != NOP) && (inst.op != END);

    //////////////////////////////////////////////////
    // Write port
    //////////////////////////////////////////////////

    assign dmem.wren    = din_v && (inst.wsrc != W_NONE);
    assign dmem.wr_addr = inst.dst;

    always_comb begin
        case (inst.wsrc)
            W_PE:    dmem.wdata = din_pe;
            W_WB:    dmem.wdata = din_wb;  // Last result, as held now
            default: dmem.wdata = din_ld;  // W_LD, W_NONE does not write
        endcase
    end

    //////////////////////////////////////////////////
    // Read ports and ALU issue
    //////////////////////////////////////////////////

    assign dmem.rden     = issue;
    assign dmem.rd_addr0 = inst.src0;
    assign dmem.rd_addr1 = inst.src1;

    // Delay one cycle to meet the registered read data
    always_ff @(posedge clk) begin
        if (rst) begin
            alu_v <= 1'b0;
        end else begin
            alu_v <= issue;
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            alu_op <= inst.op;
        end
    end

endmodule

`default_nettype wire

// File: pe/pe_dmem.sv
`timescale 1ns/1ns
`default_nettype none

module pe_dmem import pe_types_pkg::*; (
    input  wire  clk,
    dmem_if.mem  dmem
);

    cplx_t regs [DMEM_DEPTH];  // Not cleared by reset

    //////////////////////////////////////////////////
    // One write, two reads, all on the clock edge
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (dmem.wren) begin
            regs[dmem.wr_addr] <= dmem.wdata;
        end
    end

    // Same-cycle read sees the old entry
    always_ff @(posedge clk) begin
        if (dmem.rden) begin
            dmem.rdata0 <= regs[dmem.rd_addr0];
            dmem.rdata1 <= regs[dmem.rd_addr1];
        end  // Otherwise hold
    end

endmodule

`default_nettype wire

// File: pe/pe.sv
`timescale 1ns/1ns
`default_nettype none

module pe import pe_types_pkg::*, pe_isa_pkg::*; #(
    parameter int IMEM_DEPTH = 32,
    parameter int FRAC_BITS  = 8
) (
    input  wire                    clk,
    input  wire                    rst,
    input  wire                    din_v,      // One instruction per high cycle
    input  wire cplx_t             din_ld,     // Load bus
    input  wire cplx_t             din_pe,     // Neighbour bus
    input  wire                    inst_in_v,
    input  wire [INST_WIDTH-1:0]   inst_in,
    output logic                   dout_v,
    output cplx_t                  dout_pe,
    output logic                   inst_out_v,
    output logic [INST_WIDTH-1:0]  inst_out
);

    inst_t cur_inst;  // Word at the program counter
    logic  alu_v;
    op_t   alu_op;

    dmem_if dmem_bus ();

    //////////////////////////////////////////////////
    // Program pass-through to the next PE
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            inst_out_v <= 1'b0;
        end else begin
            inst_out_v <= inst_in_v;
        end
        inst_out <= inst_in;  // Payload, no reset
    end

    //////////////////////////////////////////////////
    // Blocks
    //////////////////////////////////////////////////

    pe_imem #(
        .IMEM_DEPTH (IMEM_DEPTH)
    ) u_imem (
        .clk       (clk),
        .rst       (rst),
        .inst_in_v (inst_in_v),
        .inst_in   (inst_in),
        .step      (din_v),
        .inst      (cur_inst)
    );

    pe_control u_ctrl (
        .clk    (clk),
        .rst    (rst),
        .inst   (cur_inst),
        .din_v  (din_v),
        .din_ld (din_ld),
        .din_pe (din_pe),
        .din_wb (dout_pe),   // Write-back of last result
        .dmem   (dmem_bus.ctrl),
        .alu_v  (alu_v),
        .alu_op (alu_op)
    );

    pe_dmem u_dmem (
        .clk  (clk),
        .dmem (dmem_bus.mem)
    );

    complex_alu #(
        .FRAC_BITS (FRAC_BITS)
    ) u_alu (
        .clk    (clk),
        .rst    (rst),
        .alu_v  (alu_v),
        .alu_op (alu_op),
        .opnd   (dmem_bus.alu),
        .dout_v (dout_v),
        .dout   (dout_pe)
    );

endmodule

`default_nettype wire

// File: bench/pe_tb.sv
`timescale 1ns/1ns
`default_nettype none

module pe_tb import pe_types_pkg::*, pe_isa_pkg::*; ();

    logic                  clk;
    logic                  rst;
    logic                  din_v;
    cplx_t                 din_ld;
    cplx_t                 din_pe;
    logic                  inst_in_v;
    logic [INST_WIDTH-1:0] inst_in;
    logic                  dout_v;
    cplx_t                 dout_pe;
    logic                  inst_out_v;
    logic [INST_WIDTH-1:0] inst_out;
    logic [31:0]           dout_word;   // dout_pe as a plain word

    logic [31:0]           exp_q [$];   // Expected results, oldest first
    logic [31:0]           exp_head;
    logic                  prev_in_v;   // inst_in_v one cycle back
    logic [INST_WIDTH-1:0] prev_in;
    string                 cur_name;
    bit                    in_test;
    int                    test_errs;
    int                    total_errs;
    int                    results_seen;
    int                    pass_cnt;
    int                    fail_cnt;
    int                    seed = 32'h5701_71df;
    int                    cycles;
    int                    cycle_limit;

    assign dout_word = dout_pe;

    pe #(
        .IMEM_DEPTH (32),
        .FRAC_BITS  (8)
    ) DUT (
        .clk        (clk),
        .rst        (rst),
        .din_v      (din_v),
        .din_ld     (din_ld),
        .din_pe     (din_pe),
        .inst_in_v  (inst_in_v),
        .inst_in    (inst_in),
        .dout_v     (dout_v),
        .dout_pe    (dout_pe),
        .inst_out_v (inst_out_v),
        .inst_out   (inst_out)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;  // 8 ns period
    end

    //////////////////////////////////////////////////
    // Stimulus tasks, all start and end 1 ns past a rising edge
    //////////////////////////////////////////////////

    task count_error();
        test_errs++;
        total_errs++;
    endtask

    task automatic send_beat(input logic [31:0] word);
        inst_in_v = 1'b1;
        inst_in   = word;
        @(posedge clk);
        #1;
    endtask

    // Drop inst_in_v for one cycle so the next beat starts a new burst
    task automatic end_burst();
        if (inst_in_v) begin
            inst_in_v = 1'b0;
            @(posedge clk);
            #1;
        end
    endtask

    task automatic run_step(input logic [31:0] ld, input logic [31:0] nb);
        int gap;
        din_v  = 1'b1;
        din_ld = ld;
        din_pe = nb;
        @(posedge clk);
        #1;
        din_v = 1'b0;
        gap   = $unsigned($random(seed)) % 3;  // 0 to 2 idle cycles
        repeat (gap) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic apply_reset();
        rst       = 1'b1;
        din_v     = 1'b1;          // Issue and load kept busy during reset
        inst_in_v = 1'b1;
        inst_in   = 32'h1000_0000;  // CADD r0 r0, no write
        repeat (4) @(posedge clk);
        #1;
        rst       = 1'b0;
        din_v     = 1'b0;
        inst_in_v = 1'b0;
        inst_in   = '0;
        repeat (3) begin
            @(negedge clk);
            // Nothing issued or loaded since reset
            assert (dout_v === 1'b0 && inst_out_v === 1'b0) else begin
                $display("Test %s: dout_v or inst_out_v went high after reset", cur_name);
                count_error();
            end
        end
        @(posedge clk);
        #1;
    endtask

    task automatic start_test(input string name);
        cur_name     = name;
        in_test      = 1'b1;
        test_errs    = 0;
        results_seen = 0;
    endtask

    task automatic finish_test();
        int waited;
        waited = 0;
        while (exp_q.size() > 0 && waited < 20) begin  // Drain in-flight results
            @(posedge clk);
            #1;
            waited++;
        end
        repeat (2) begin  // A stray result right behind the last one
            @(posedge clk);
            #1;
        end
        assert (exp_q.size() == 0) else begin
            while (exp_q.size() > 0) begin
                $display("Test %s: expected result %h was never produced",
                         cur_name, exp_q.pop_front());
                count_error();
            end
        end
        if (in_test) begin
            if (test_errs == 0) begin
                pass_cnt++;
            end else begin
                fail_cnt++;
            end
            $display("Test %s: %s, %0d results, %0d errors", cur_name,
                     (test_errs == 0) ? "ok" : "failed", results_seen, test_errs);
        end
        in_test = 1'b0;
    endtask

    //////////////////////////////////////////////////
    // Output monitor, sampled on the falling edge
    //////////////////////////////////////////////////

    always @(negedge clk) begin
        if (rst === 1'b0) begin
            assert (inst_out_v === prev_in_v) else begin
                $display("FAILED %s: inst_out_v expected %b, got %b",
                         cur_name, prev_in_v, inst_out_v);
                count_error();
            end
            if (prev_in_v) begin
                assert (inst_out === prev_in) else begin
                    $display("FAILED %s: inst_out expected %h, got %h",
                             cur_name, prev_in, inst_out);
                    count_error();
                end
            end
            if (dout_v === 1'b1) begin
                assert (exp_q.size() > 0) else begin
                    $display("Test %s: result %h appeared with no expected value left",
                             cur_name, dout_word);
                    count_error();
                end
                if (exp_q.size() > 0) begin
                    exp_head = exp_q.pop_front();
                    results_seen++;
                    assert (dout_word === exp_head) else begin
                        $display("FAILED %s: expected %h, got %h",
                                 cur_name, exp_head, dout_word);
                        count_error();
                    end
                end
            end
        end
        // A reset edge clears inst_out_v
        prev_in_v = rst ? 1'b0 : inst_in_v;  // Compared on the next falling edge
        prev_in   = inst_in;
    end

    // Run limit scales with the cases file
    initial begin
        cycles = 0;
        wait (cycle_limit > 0);
        while (cycles < cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout after %0d cycles, the cases did not complete", cycles);
        $display("Simulation FAILED");
        $finish;
    end

    //////////////////////////////////////////////////
    // Main sequence, one cases line at a time
    //////////////////////////////////////////////////

    initial begin
        int          fd;
        int          n;
        string       line;
        string       kind;
        string       name;
        string       lines [$];
        logic [31:0] word_a;
        logic [31:0] word_b;

        rst        = 1'b1;
        din_v      = 1'b0;
        din_ld     = '0;
        din_pe     = '0;
        inst_in_v  = 1'b0;
        inst_in    = '0;
        prev_in_v  = 1'b0;
        prev_in    = '0;
        cur_name   = "startup";
        in_test    = 1'b0;
        test_errs  = 0;
        total_errs = 0;
        pass_cnt   = 0;
        fail_cnt   = 0;
        cycle_limit = 0;

        fd = $fopen("bench/pe_cases.txt", "r");
        if (fd == 0) begin
            $display("Could not open bench/pe_cases.txt");
            total_errs++;
        end else begin
            while ($fgets(line, fd) > 0) begin
                lines.push_back(line);
            end
            $fclose(fd);
            cycle_limit = 8 * lines.size() + 100;
            foreach (lines[i]) begin
                n = $sscanf(lines[i], "%s", kind);
                if (n >= 1 && kind.substr(0, 0) != "#") begin  // Skip comment lines
                    if (kind == "T") begin
                        end_burst();
                        finish_test();
                        n = $sscanf(lines[i], "%s %s", kind, name);
                        start_test(name);
                    end else if (kind == "P") begin
                        n = $sscanf(lines[i], "%s %h", kind, word_a);
                        send_beat(word_a);
                    end else if (kind == "D") begin
                        end_burst();
                        n = $sscanf(lines[i], "%s %h %h", kind, word_a, word_b);
                        run_step(word_a, word_b);
                    end else if (kind == "E") begin
                        n = $sscanf(lines[i], "%s %h", kind, word_a);
                        exp_q.push_back(word_a);
                    end else if (kind == "R") begin
                        end_burst();
                        apply_reset();
                    end else begin
                        $display("Cases line %0d has an unknown kind %s", i + 1, kind);
                        total_errs++;
                    end
                end
            end
        end
        end_burst();
        finish_test();

        $display("Tests passed: %0d, failed: %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0 && total_errs == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: bench/pe_cases.txt
# T name | P instruction word | D din_ld din_pe | E expected dout_pe | R reset
# All values in hex, E lines come before the D steps that produce them
R
T add_sub
P 04000000
P 08400000
P 10004000
P 20004000
P f0000000
E 80000000
E 7ffe0020
D 7fff0010 00000000
D 00000000 0001fff0
D 00000000 00000000
D 00000000 00000000
D 00000000 00000000
T mul
P 04800000
P 04c00000
P 3008c000
P 4008c000
P f0000000
E ffe00240
E fde000c0
D 0180fe00 00000000
D ff400080 00000000
D 00000000 00000000
D 00000000 00000000
D 00000000 00000000
T write_back
P 05000000
P 05400000
P 10114000
P 00000000
P 0d800000
P 50180000
P f0000000
E 23456789
E 23456789
D 12345678 00000000
D 11111111 00000000
D 00000000 00000000
D 00000000 00000000
D 00000000 00000000
D 00000000 00000000
D 00000000 00000000
T restart_reload
P 10004000
P f0000000
E 80000000
E 80000000
D 00000000 00000000
D 00000000 00000000
D 00000000 00000000
D 00000000 00000000
P 50080000
P 200c8000
E 0180fe00
E fdc00280
E 0180fe00
D 00000000 00000000
D 00000000 00000000
D 00000000 00000000
T reset_idle
R
P 50100000
E 12345678
D 00000000 00000000

// File: sources.f
common/pe_types_pkg.sv
common/pe_isa_pkg.sv
common/dmem_if.sv
hw/complex_alu.sv
pe/pe_imem.sv
pe/pe_control.sv
pe/pe_dmem.sv
pe/pe.sv
bench/pe_tb.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f sources.f --top-module pe_tb -o pe_sim &&
./obj_dir/pe_sim | tee /dev/stderr | grep -q "Simulation PASSED" &&
echo "run passed" || { echo "run failed"; exit 1; }
